/* design/control_sequencer.sv */
`timescale 1ns/1ps

module control_sequencer import cu_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic [2:0]     flags,
    input  operand_count_t num_operand_bytes,
    input  control_word_t  rom_word,
    output microstep_t     microstep,
    output control_word_t  control_word
);

    fsm_state_t state;
    fsm_state_t next_state;
    microstep_t next_microstep;
    logic [1:0] byte_count;      // Bytes fetched so far, up to 3
    logic [1:0] next_byte_count;
    alu_op_t    alu_op_q;
    logic       latch_alu_op;
    logic       check_jump;
    logic       jump_taken;

    // ==============================
    // Branch resolution
    // ==============================
    assign check_jump = rom_word.check_zero     | rom_word.check_not_zero  |
                        rom_word.check_carry    | rom_word.check_not_carry |
                        rom_word.check_negative | rom_word.check_not_negative;

    assign jump_taken = (rom_word.check_zero         &  flags[STATUS_ZERO])  |
                        (rom_word.check_not_zero     & ~flags[STATUS_ZERO])  |
                        (rom_word.check_carry        &  flags[STATUS_CARRY]) |
                        (rom_word.check_not_carry    & ~flags[STATUS_CARRY]) |
                        (rom_word.check_negative     &  flags[STATUS_NEG])   |
                        (rom_word.check_not_negative & ~flags[STATUS_NEG]);

    // ALU op is captured only on the first microstep
    assign latch_alu_op = (state == S_EXECUTE) && (microstep == MS0) &&
                          (rom_word.alu_op != ALU_UNDEFINED);

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            microstep  <= MS0;
            byte_count <= 2'd0;
            alu_op_q   <= ALU_UNDEFINED;
        end else begin
            state      <= next_state;
            microstep  <= next_microstep;
            byte_count <= next_byte_count;
            if (latch_alu_op) begin
                alu_op_q <= rom_word.alu_op; // Visible from the next cycle
            end
        end
    end

    // ==============================
    // Next state and control word
    // ==============================
    always_comb begin
        next_state      = state;
        next_microstep  = microstep;
        next_byte_count = byte_count;
        control_word    = '0;

        case (state)
            S_RESET: begin
                next_state = S_INIT;
            end

            S_INIT: begin
                control_word.load_origin = 1'b1; // PC to program origin
                next_state               = S_LATCH_ADDR;
            end

            S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state               = S_READ_BYTE;
            end

            S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;
                next_state          = S_LATCH_BYTE;
            end

            S_LATCH_BYTE: begin
                control_word.oe_ram    = 1'b1;
                control_word.pc_enable = 1'b1;
                case (byte_count)
                    2'd0:    control_word.load_ir     = 1'b1; // Opcode
                    2'd1:    control_word.load_temp_1 = 1'b1; // Low operand
                    2'd2:    control_word.load_temp_2 = 1'b1; // High operand
                    default: ;
                endcase
                next_byte_count = byte_count + 2'd1;
                next_state      = S_CHK_MORE_BYTES;
            end

            S_CHK_MORE_BYTES: begin
                // Opcode is valid here, one cycle after load_ir
                if (byte_count > num_operand_bytes) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = 2'd0;
                    next_microstep  = MS0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end

            S_EXECUTE: begin
                control_word = rom_word;
                if (rom_word.halt) begin
                    next_state     = S_HALT;
                    next_microstep = MS0;
                end else if (check_jump && !jump_taken) begin
                    // Jump not taken, keep the PC and refetch
                    control_word.load_pc_low_byte  = 1'b0;
                    control_word.load_pc_high_byte = 1'b0;
                    next_state                     = S_LATCH_ADDR;
                    next_microstep                 = MS0;
                end else if (rom_word.last_step) begin
                    next_state     = S_LATCH_ADDR;
                    next_microstep = MS0;
                end else begin
                    next_microstep = microstep_t'((int'(microstep) + 1) % MAX_MICROSTEPS);
                end
            end

            S_HALT: begin
                next_state = S_HALT; // Left only through reset
            end
        endcase

        control_word.alu_op = alu_op_q; // Latched op on every word
    end

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ps

module control_unit import cu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  logic [2:0]    flags,
    output control_word_t control_word
);

    operand_count_t num_operand_bytes;
    microstep_t     microstep;
    control_word_t  rom_word;

    operand_decoder i_operand_decoder (
        .opcode            (opcode),
        .num_operand_bytes (num_operand_bytes)
    );

    microcode_rom i_microcode_rom (
        .opcode    (opcode),
        .microstep (microstep),
        .rom_word  (rom_word)
    );

    control_sequencer i_control_sequencer (
        .clk               (clk),
        .reset             (reset),
        .flags             (flags),
        .num_operand_bytes (num_operand_bytes),
        .rom_word          (rom_word),
        .microstep         (microstep),
        .control_word      (control_word)
    );

endmodule

/* design/cu_pkg.sv */
package cu_pkg;

    // ==============================
    // Instruction set
    // ==============================
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        // Branching
        JMP    = 8'h10,
        JZ     = 8'h11,
        JNZ    = 8'h12,
        JN     = 8'h13,
        JNN    = 8'h14,
        JC     = 8'h15,
        JNC    = 8'h16,
        // ALU on accumulator
        ADD_B  = 8'h20,
        SUB_B  = 8'h21,
        ANA_B  = 8'h22,
        ORA_B  = 8'h23,
        XRA_B  = 8'h24,
        CMP_B  = 8'h25,
        INR_A  = 8'h26,
        DCR_A  = 8'h27,
        ANI    = 8'h28,
        // Moves and immediates
        MOV_AB = 8'h30,
        MOV_BA = 8'h31,
        LDI_A  = 8'h32,
        LDI_B  = 8'h33,
        // Memory
        LDA    = 8'h40,
        STA    = 8'h41,
        // Carry flag
        SEC    = 8'h50,
        CLC    = 8'h51
    } opcode_t;

    // ==============================
    // Sequencer
    // ==============================
    typedef enum logic [2:0] {
        S_RESET, S_INIT, S_LATCH_ADDR, S_READ_BYTE,
        S_LATCH_BYTE, S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    localparam int MAX_MICROSTEPS = 8; // Length of one microcode row

    typedef logic [1:0] operand_count_t; // 0 to 2 operand bytes

    typedef enum logic [3:0] {
        ALU_UNDEFINED = 4'h0, // Also the all-zero word value
        ALU_ADD       = 4'h1,
        ALU_SUB       = 4'h2,
        ALU_AND       = 4'h3,
        ALU_OR        = 4'h4,
        ALU_XOR       = 4'h5,
        ALU_INR       = 4'h6,
        ALU_DCR       = 4'h7
    } alu_op_t;

    // Bit positions in the flags input
    localparam int STATUS_ZERO  = 0;
    localparam int STATUS_CARRY = 1;
    localparam int STATUS_NEG   = 2;

    // ==============================
    // Control word
    // ==============================
    typedef struct packed {
        logic    load_origin;
        logic    load_mar_pc;
        logic    oe_ram;
        logic    pc_enable;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    check_negative;
        logic    check_not_negative;
        logic    oe_alu;
        logic    oe_a;
        logic    oe_b;
        logic    load_a;
        logic    load_b;
        logic    load_status;
        logic    load_sets_zn;  // Status takes Z/N from the bus value
        logic    alu_src2_temp1;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    load_ram;
        logic    set_carry_flag;
        logic    clear_carry_flag;
        logic    last_step;
        logic    halt;
        alu_op_t alu_op;
    } control_word_t;

endpackage

/* design/microcode_rom.sv */
`timescale 1ns/1ps

module microcode_rom import cu_pkg::*; (
    input  opcode_t       opcode,
    input  microstep_t    microstep,
    output control_word_t rom_word
);

    always_comb begin
        rom_word = '0; // Unused steps stay all zero

        case (opcode)
            NOP: begin
                rom_word.last_step = (microstep == MS0);
            end

            HLT: begin
                rom_word.halt = (microstep == MS0);
            end

            // ==============================
            // Branching
            // ==============================
            JMP, JZ, JNZ, JN, JNN, JC, JNC: begin
                case (microstep)
                    MS0: begin
                        rom_word.oe_temp_1          = 1'b1;
                        rom_word.load_pc_low_byte   = 1'b1;
                        // At most one check, none for JMP
                        rom_word.check_zero         = (opcode == JZ);
                        rom_word.check_not_zero     = (opcode == JNZ);
                        rom_word.check_negative     = (opcode == JN);
                        rom_word.check_not_negative = (opcode == JNN);
                        rom_word.check_carry        = (opcode == JC);
                        rom_word.check_not_carry    = (opcode == JNC);
                    end
                    MS1: begin
                        rom_word.oe_temp_2         = 1'b1;
                        rom_word.load_pc_high_byte = 1'b1;
                        rom_word.last_step         = 1'b1;
                    end
                    default: ;
                endcase
            end

            // ==============================
            // ALU
            // ==============================
            ADD_B, SUB_B, ANA_B, ORA_B, XRA_B, CMP_B, INR_A, DCR_A, ANI: begin
                case (microstep)
                    MS0: begin
                        case (opcode)
                            ADD_B:        rom_word.alu_op = ALU_ADD;
                            SUB_B, CMP_B: rom_word.alu_op = ALU_SUB;
                            ANA_B, ANI:   rom_word.alu_op = ALU_AND;
                            ORA_B:        rom_word.alu_op = ALU_OR;
                            XRA_B:        rom_word.alu_op = ALU_XOR;
                            INR_A:        rom_word.alu_op = ALU_INR;
                            default:      rom_word.alu_op = ALU_DCR;
                        endcase
                        rom_word.oe_temp_1      = (opcode == ANI); // Immediate as source 2
                        rom_word.alu_src2_temp1 = (opcode == ANI);
                    end
                    MS1: begin
                        rom_word.oe_alu      = (opcode != CMP_B); // Compare only sets flags
                        rom_word.load_a      = (opcode != CMP_B);
                        rom_word.load_status = (opcode != ADD_B);
                        rom_word.last_step   = (opcode != ADD_B);
                    end
                    MS2: begin
                        // ADD_B updates status one step later
                        rom_word.load_status = (opcode == ADD_B);
                        rom_word.last_step   = (opcode == ADD_B);
                    end
                    default: ;
                endcase
            end

            // ==============================
            // Moves, immediates, carry
            // ==============================
            MOV_AB, MOV_BA, LDI_A, LDI_B, SEC, CLC: begin
                if (microstep == MS0) begin
                    rom_word.oe_a             = (opcode == MOV_AB);
                    rom_word.oe_b             = (opcode == MOV_BA);
                    rom_word.oe_temp_1        = (opcode == LDI_A) || (opcode == LDI_B);
                    rom_word.load_a           = (opcode == MOV_BA) || (opcode == LDI_A);
                    rom_word.load_b           = (opcode == MOV_AB) || (opcode == LDI_B);
                    rom_word.load_sets_zn     = (opcode == LDI_A) || (opcode == LDI_B);
                    rom_word.load_status      = !((opcode == MOV_AB) || (opcode == MOV_BA));
                    rom_word.set_carry_flag   = (opcode == SEC);
                    rom_word.clear_carry_flag = (opcode == CLC);
                    rom_word.last_step        = 1'b1;
                end
            end

            // ==============================
            // Memory
            // ==============================
            LDA, STA: begin
                case (microstep)
                    MS0, MS1: begin
                        rom_word.oe_temp_1         = 1'b1;
                        rom_word.load_mar_addr_low = (microstep == MS1);
                    end
                    MS2, MS3: begin
                        rom_word.oe_temp_2          = 1'b1;
                        rom_word.load_mar_addr_high = (microstep == MS3);
                    end
                    MS4, MS5: begin
                        rom_word.oe_ram = (opcode == LDA);
                        rom_word.oe_a   = (opcode == STA);
                    end
                    default: ;
                endcase
                if (microstep == MS5) begin
                    rom_word.load_a       = (opcode == LDA);
                    rom_word.load_status  = (opcode == LDA);
                    rom_word.load_sets_zn = (opcode == LDA);
                    rom_word.load_ram     = (opcode == STA);
                    rom_word.last_step    = 1'b1;
                end
            end

            default: begin
                rom_word.halt = 1'b1; // Unknown opcode stops the CPU
            end
        endcase
    end

endmodule

/* design/operand_decoder.sv */
`timescale 1ns/1ps

module operand_decoder import cu_pkg::*; (
    input  opcode_t        opcode,
    output operand_count_t num_operand_bytes
);

    // Instruction length minus the opcode byte
    always_comb begin
        case (opcode)
            // Immediate operand
            LDI_A, LDI_B, ANI: begin
                num_operand_bytes = 2'd1;
            end

            // 16-bit address, low byte first
            JMP, JZ, JNZ, JN, JNN, JC, JNC, LDA, STA: begin
                num_operand_bytes = 2'd2;
            end

            // Implied operands, and anything not in the table
            default: begin
                num_operand_bytes = 2'd0;
            end
        endcase
    end

endmodule

/* dv/control_unit_checker.sv */
`timescale 1ns/1ps

module control_unit_checker import cu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  logic [2:0]    flags,
    input  control_word_t control_word,
    input  int            test_id,
    input  logic          test_end,
    output int            error_count
);

    // Model of the sequencer
    fsm_state_t    m_state;
    int            m_bytes;
    int            m_step;
    alu_op_t       m_alu;
    bit            started      = 1'b0; // Set once reset has been seen
    int            errors       = 0;
    int            test_errors  = 0;
    int            current_test = 0;
    control_word_t expected;

    assign error_count = errors;

    // ==============================
    // ISA rules
    // ==============================
    function automatic int operand_count(input opcode_t op);
        case (op)
            LDI_A, LDI_B, ANI:                        return 1;
            JMP, JZ, JNZ, JN, JNN, JC, JNC, LDA, STA: return 2;
            default:                                  return 0;
        endcase
    endfunction

    function automatic alu_op_t alu_of(input opcode_t op);
        case (op)
            ADD_B:        return ALU_ADD;
            SUB_B, CMP_B: return ALU_SUB;
            ANA_B, ANI:   return ALU_AND;
            ORA_B:        return ALU_OR;
            XRA_B:        return ALU_XOR;
            INR_A:        return ALU_INR;
            DCR_A:        return ALU_DCR;
            default:      return ALU_UNDEFINED;
        endcase
    endfunction

    // JMP and non-jumps always count as taken
    function automatic logic jump_taken(input opcode_t op, input logic [2:0] f);
        case (op)
            JZ:      return f[STATUS_ZERO];
            JNZ:     return !f[STATUS_ZERO];
            JC:      return f[STATUS_CARRY];
            JNC:     return !f[STATUS_CARRY];
            JN:      return f[STATUS_NEG];
            JNN:     return !f[STATUS_NEG];
            default: return 1'b1;
        endcase
    endfunction

    // Microcode table, alu_op left at zero
    function automatic control_word_t microcode(input opcode_t op, input int step);
        control_word_t w;
        w = '0;
        case (op)
            NOP: w.last_step = (step == 0);
            HLT: w.halt = (step == 0);
            JMP, JZ, JNZ, JN, JNN, JC, JNC: begin
                w.oe_temp_1          = (step == 0);
                w.load_pc_low_byte   = (step == 0);
                w.check_zero         = (step == 0) && (op == JZ);
                w.check_not_zero     = (step == 0) && (op == JNZ);
                w.check_carry        = (step == 0) && (op == JC);
                w.check_not_carry    = (step == 0) && (op == JNC);
                w.check_negative     = (step == 0) && (op == JN);
                w.check_not_negative = (step == 0) && (op == JNN);
                w.oe_temp_2          = (step == 1);
                w.load_pc_high_byte  = (step == 1);
                w.last_step          = (step == 1);
            end
            ADD_B: begin
                w.oe_alu      = (step == 1);
                w.load_a      = (step == 1);
                w.load_status = (step == 2); // Status one step after the result
                w.last_step   = (step == 2);
            end
            SUB_B, ANA_B, ORA_B, XRA_B, CMP_B, INR_A, DCR_A, ANI: begin
                w.oe_temp_1      = (op == ANI) && (step == 0);
                w.alu_src2_temp1 = (op == ANI) && (step == 0);
                w.oe_alu         = (op != CMP_B) && (step == 1);
                w.load_a         = (op != CMP_B) && (step == 1);
                w.load_status    = (step == 1);
                w.last_step      = (step == 1);
            end
            MOV_AB, MOV_BA, LDI_A, LDI_B, SEC, CLC: begin
                if (step == 0) begin
                    w.oe_a             = (op == MOV_AB);
                    w.oe_b             = (op == MOV_BA);
                    w.oe_temp_1        = (op == LDI_A) || (op == LDI_B);
                    w.load_a           = (op == MOV_BA) || (op == LDI_A);
                    w.load_b           = (op == MOV_AB) || (op == LDI_B);
                    w.load_sets_zn     = (op == LDI_A) || (op == LDI_B);
                    w.load_status      = (op != MOV_AB) && (op != MOV_BA);
                    w.set_carry_flag   = (op == SEC);
                    w.clear_carry_flag = (op == CLC);
                    w.last_step        = 1'b1;
                end
            end
            LDA, STA: begin
                w.oe_temp_1          = (step <= 1);          // Address low byte
                w.load_mar_addr_low  = (step == 1);
                w.oe_temp_2          = (step == 2) || (step == 3);
                w.load_mar_addr_high = (step == 3);
                w.oe_ram             = (op == LDA) && (step >= 4) && (step <= 5);
                w.oe_a               = (op == STA) && (step >= 4) && (step <= 5);
                w.load_a             = (op == LDA) && (step == 5);
                w.load_status        = (op == LDA) && (step == 5);
                w.load_sets_zn       = (op == LDA) && (step == 5);
                w.load_ram           = (op == STA) && (step == 5);
                w.last_step          = (step == 5);
            end
            default: w.halt = 1'b1; // Unknown opcode halts at every step
        endcase
        return w;
    endfunction

    function automatic logic jump_skipped();
        return (m_step == 0) && !jump_taken(opcode, flags);
    endfunction

    function automatic control_word_t expected_word();
        control_word_t w;
        w = '0;
        case (m_state)
            S_INIT:       w.load_origin = 1'b1;
            S_LATCH_ADDR: w.load_mar_pc = 1'b1;
            S_READ_BYTE:  w.oe_ram = 1'b1;
            S_LATCH_BYTE: begin
                w.oe_ram      = 1'b1;
                w.pc_enable   = 1'b1;
                w.load_ir     = (m_bytes == 0);
                w.load_temp_1 = (m_bytes == 1);
                w.load_temp_2 = (m_bytes == 2);
            end
            S_EXECUTE: begin
                w = microcode(opcode, m_step);
                if (jump_skipped()) begin
                    w.load_pc_low_byte  = 1'b0;
                    w.load_pc_high_byte = 1'b0;
                end
            end
            default: ;
        endcase
        w.alu_op = m_alu;
        return w;
    endfunction

    // ==============================
    // Model step and comparison
    // ==============================
    task automatic advance_model();
        control_word_t w;
        case (m_state)
            S_RESET:      m_state = S_INIT;
            S_INIT:       m_state = S_LATCH_ADDR;
            S_LATCH_ADDR: m_state = S_READ_BYTE;
            S_READ_BYTE:  m_state = S_LATCH_BYTE;
            S_LATCH_BYTE: begin
                m_bytes = m_bytes + 1;
                m_state = S_CHK_MORE_BYTES;
            end
            S_CHK_MORE_BYTES: begin
                if (m_bytes > operand_count(opcode)) begin
                    m_state = S_EXECUTE;
                    m_bytes = 0;
                    m_step  = 0;
                end else begin
                    m_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                w = microcode(opcode, m_step);
                if ((m_step == 0) && (alu_of(opcode) != ALU_UNDEFINED)) begin
                    m_alu = alu_of(opcode);
                end
                if (w.halt) begin
                    m_state = S_HALT;
                end else if (jump_skipped() || w.last_step) begin
                    m_state = S_LATCH_ADDR;
                    m_step  = 0;
                end else begin
                    m_step = m_step + 1;
                end
            end
            default: ; // S_HALT holds
        endcase
    endtask

    always @(posedge clk) begin
        expected = expected_word();
        if (started && (control_word !== expected)) begin
            $display("Error: control_word expected %h, got %h (model state %s, step %0d)",
                     expected, control_word, m_state.name(), m_step);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
        if (test_end) begin
            $display("Test %0d finished with %0d errors", current_test, test_errors);
            test_errors = 0;
        end
        current_test = test_id;
        if (reset) begin
            m_state = S_RESET;
            m_bytes = 0;
            m_step  = 0;
            m_alu   = ALU_UNDEFINED;
            started = 1'b1;
        end else if (started) begin
            advance_model();
        end
    end

endmodule

/* dv/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb import cu_pkg::*; ();

    localparam int N_INIT         = 4;
    localparam int N_FETCH        = 100;
    localparam int N_EXEC         = 100;
    localparam int N_JUMP         = 100;
    localparam int N_HALT         = 6;  // Random lead-in plus HLT
    localparam int N_UNKNOWN      = 1;
    localparam int NUM_TESTS      = 6;
    localparam int HALT_HOLD      = 20;
    localparam int TOTAL_INSTR    = N_INIT + N_FETCH + N_EXEC + N_JUMP + N_HALT + N_UNKNOWN;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_INSTR * 20 + 100;

    // Jumps sit at 0 to 6 and ALU ops at 7 to 15
    // Moves 16 to 19, memory 20 and 21, carry 22 and 23, then NOP and HLT
    localparam logic [26*8-1:0] OP_POOL = {
        JMP, JZ, JNZ, JN, JNN, JC, JNC,
        ADD_B, SUB_B, ANA_B, ORA_B, XRA_B, CMP_B, INR_A, DCR_A, ANI,
        MOV_AB, MOV_BA, LDI_A, LDI_B,
        LDA, STA, SEC, CLC, NOP, HLT
    };

    logic          clk;
    logic          reset;
    opcode_t       opcode;
    logic [2:0]    flags;
    control_word_t control_word;
    int            test_id;
    logic          test_end;
    int            error_count;
    int            cycle_count = 0;
    int            seed_value;
    bit            at_load_ir;  // A load_ir cycle still waits for its opcode
    opcode_t       instr_queue[$];

    control_unit i_control_unit (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word)
    );

    control_unit_checker i_control_unit_checker (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .test_id      (test_id),
        .test_end     (test_end),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles before all tests finished", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic opcode_t opcode_at(input int index);
        return opcode_t'(OP_POOL[8*(25-index) +: 8]);
    endfunction

    function automatic opcode_t unknown_opcode();
        logic [7:0] value;
        bit         known;
        known = 1'b1;
        while (known) begin
            value = 8'($urandom % 256);
            known = 1'b0;
            for (int i = 0; i < 26; i++) begin
                if (opcode_at(i) == value) known = 1'b1;
            end
        end
        return opcode_t'(value);
    endfunction

    task automatic next_negedge();
        @(negedge clk);
        test_end   = 1'b0;
        at_load_ir = control_word.load_ir;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) next_negedge();
        reset      = 1'b0;
        at_load_ir = 1'b0;
    endtask

    // Feeds one queued opcode per load_ir with fresh flags
    task automatic run_program(input int id, input bit until_halt);
        test_id = id;
        forever begin
            if (at_load_ir) begin
                if (instr_queue.size() == 0) break; // Last instruction has completed
                opcode     = instr_queue.pop_front();
                flags      = 3'($urandom % 8);
                at_load_ir = 1'b0;
            end
            if (until_halt && (instr_queue.size() == 0) && control_word.halt) break;
            next_negedge();
        end
        if (until_halt) begin
            repeat (HALT_HOLD) next_negedge();
        end
        test_end = 1'b1;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        reset      = 1'b1;
        opcode     = NOP;
        flags      = 3'b000;
        test_id    = 0;
        test_end   = 1'b0;
        at_load_ir = 1'b0;
        seed_value = $urandom(32'h8f78_8ce7);
        apply_reset();

        repeat (N_INIT) instr_queue.push_back(NOP); // Reset, init and first fetches
        run_program(1, 1'b0);

        repeat (N_FETCH) instr_queue.push_back(opcode_at($urandom % 25));
        run_program(2, 1'b0);

        repeat (N_EXEC) instr_queue.push_back(opcode_at(7 + $urandom % 18));
        run_program(3, 1'b0);

        repeat (N_JUMP) instr_queue.push_back(opcode_at($urandom % 7));
        run_program(4, 1'b0);

        repeat (N_HALT - 1) instr_queue.push_back(opcode_at(7 + $urandom % 18));
        instr_queue.push_back(HLT);
        run_program(5, 1'b1);

        apply_reset();
        instr_queue.push_back(unknown_opcode());
        run_program(6, 1'b1);
        next_negedge(); // Checker reports the last test

        $display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/cu_pkg.sv
design/operand_decoder.sv
design/microcode_rom.sv
design/control_sequencer.sv
design/control_unit.sv
dv/control_unit_checker.sv
dv/control_unit_tb.sv
